// File: logic/rvPkg.sv
/*
 * Shared sizes and encodings for the RV32I multicycle core
 */
package rvPkg;

	// Data path width
	localparam int xlen = 32;

	// Memory sizes in words
	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;
	localparam int memAddrBits = $clog2(imemDepth);

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeT;

	// ALU functions, pass-B serves LUI
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	// Sequencer states
	typedef enum logic [2:0] {
		sIdle, sFetch, sDecode, sExecute, sMemory, sWriteback, sHalt
	} stateT;

	// Write-back source
	typedef enum logic [1:0] {
		wbAlu, wbMem, wbLink
	} wbSelT;

endpackage

// File: logic/ctrlIf.sv
/*
 * Control bundle from the sequencer to the datapath blocks
 */
interface ctrlIf;
	import rvPkg::*;

	// Instruction register capture
	logic irLoad;
	// Register file write enable
	logic regWrite;
	// ALU function and operand selects
	aluOpT aluOp;
	logic aluSrcA;
	logic aluSrcB;
	// PC update strobes
	logic pcInc;
	logic pcLoad;
	// Data memory write
	logic memWrite;
	// Write-back source and retire strobe
	wbSelT wbSel;
	logic retire;

	modport fsm (
		output irLoad, regWrite, aluOp, aluSrcA, aluSrcB,
		output pcInc, pcLoad, memWrite, wbSel, retire
	);

	modport dp (
		input irLoad, regWrite, aluOp, aluSrcA, aluSrcB,
		input pcInc, pcLoad, memWrite, wbSel, retire
	);

endinterface

// File: logic/immediateExtender.sv
/*
 * Immediate extender
 * Builds the sign- or zero-extended immediate for each RV32I format
 */
module immediateExtender (
	input  logic [31:0]        instruction,
	output logic signed [31:0] imm
);
	import rvPkg::*;

	opcodeT opcode;
	logic [2:0] funct3;
	logic isShift;

	assign opcode = opcodeT'(instruction[6:0]);
	assign funct3 = instruction[14:12];

	// SLLI and SRLI/SRAI carry a shift amount, not a signed value
	assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

	always_comb begin
		case (opcode)
			// U type, upper 20 bits
			opLui, opAuipc: begin
				imm = {instruction[31:12], 12'b0};
			end
			// J type
			opJal: begin
				imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
					instruction[30:21], 1'b0};
			end
			// I type
			opJalr, opLoad: begin
				imm = {{21{instruction[31]}}, instruction[30:20]};
			end
			// B type, always even
			opBranch: begin
				imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
					instruction[11:8], 1'b0};
			end
			// S type, offset split around rs2
			opStore: begin
				imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
			end
			opImm: begin
				// Bit 30 of SRAI must not leak into the amount
				imm = isShift ? {27'b0, instruction[24:20]}
					: {{21{instruction[31]}}, instruction[30:20]};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// File: logic/registerFile.sv
/*
 * Integer register file, 32 entries
 * Two combinational read ports, one clocked write port, x0 fixed at zero
 */
module registerFile (
	input  logic                   clk,
	input  logic                   arstN,
	ctrlIf.dp                      ctrl,
	input  logic [4:0]             rs1Addr,
	input  logic [4:0]             rs2Addr,
	input  logic [4:0]             rdAddr,
	input  logic [rvPkg::xlen-1:0] rdData,
	output logic [rvPkg::xlen-1:0] rs1Data,
	output logic [rvPkg::xlen-1:0] rs2Data
);
	import rvPkg::*;

	logic [xlen-1:0] regs [32];

	// x0 is never written, so it keeps its reset value
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && (rdAddr != 5'd0)) begin
			regs[rdAddr] <= rdData;
		end
	end

	// Reads see the old value during a write cycle
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	// Writes aimed at x0 are dropped
	assert property (@(posedge clk) disable iff (!arstN)
		(ctrl.regWrite && (rdAddr == 5'd0)) |=> (regs[0] == '0));

endmodule

// File: logic/arithmeticUnit.sv
/*
 * ALU with branch comparator
 * Result from aluOp, branch decision from funct3 on the same operands
 */
module arithmeticUnit (
	input  logic [rvPkg::xlen-1:0] opA,
	input  logic [rvPkg::xlen-1:0] opB,
	input  rvPkg::aluOpT           aluOp,
	input  logic [2:0]             funct3,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   branchTaken
);
	import rvPkg::*;

	logic [4:0] shamt;
	logic equal;
	logic lessSigned;
	logic lessUnsigned;

	// Only the low five bits shift
	assign shamt = opB[4:0];

	// Comparisons shared by SLT/SLTU and the branches
	assign equal = (opA == opB);
	assign lessSigned = ($signed(opA) < $signed(opB));
	assign lessUnsigned = (opA < opB);

	always_comb begin
		case (aluOp)
			aluAdd:   result = opA + opB;
			aluSub:   result = opA - opB;
			aluSll:   result = opA << shamt;
			aluSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
			aluSltu:  result = {{(xlen-1){1'b0}}, lessUnsigned};
			aluXor:   result = opA ^ opB;
			aluSrl:   result = opA >> shamt;
			// Arithmetic shift keeps the sign
			aluSra:   result = $unsigned($signed(opA) >>> shamt);
			aluOr:    result = opA | opB;
			aluAnd:   result = opA & opB;
			aluPassB: result = opB;
			default:  result = '0;
		endcase
	end

	// BEQ BNE BLT BGE BLTU BGEU
	always_comb begin
		case (funct3)
			3'b000:  branchTaken = equal;
			3'b001:  branchTaken = !equal;
			3'b100:  branchTaken = lessSigned;
			3'b101:  branchTaken = !lessSigned;
			3'b110:  branchTaken = lessUnsigned;
			3'b111:  branchTaken = !lessUnsigned;
			// 010 and 011 are not branches
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: logic/programCounter.sv
/*
 * Program counter
 * Steps by four or loads a jump target with bit 0 cleared
 */
module programCounter (
	input  logic                   clk,
	input  logic                   arstN,
	ctrlIf.dp                      ctrl,
	input  logic [rvPkg::xlen-1:0] target,
	output logic [rvPkg::xlen-1:0] pc
);
	import rvPkg::*;

	// Run always starts at address zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (ctrl.pcLoad) begin
			// JALR target may be odd
			pc <= {target[xlen-1:1], 1'b0};
		end else if (ctrl.pcInc) begin
			pc <= pc + xlen'(4);
		end
	end

	// Sequencer picks exactly one update per instruction
	assert property (@(posedge clk) disable iff (!arstN)
		!(ctrl.pcInc && ctrl.pcLoad));

	// Instruction fetch stays word aligned
	assert property (@(posedge clk) disable iff (!arstN)
		pc[1:0] == 2'b00);

endmodule

// File: logic/wordMemory.sv
/*
 * Word RAM with synchronous read
 * Serves as both instruction and data memory
 */
module wordMemory #(
	parameter int depth = 2 ** rvPkg::memAddrBits
) (
	input  logic                          clk,
	input  logic                          we,
	input  logic [rvPkg::memAddrBits-1:0] addr,
	input  logic [rvPkg::xlen-1:0]        wdata,
	output logic [rvPkg::xlen-1:0]        rdata
);
	import rvPkg::*;

	logic [xlen-1:0] mem [depth];

	// Read-before-write on the same address
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

	// Address port must cover the whole array
	initial begin
		assert (depth <= 2 ** memAddrBits);
	end

endmodule

// File: logic/controlFsm.sv
/*
 * Multicycle sequencer
 * Walks fetch, decode, execute, memory and write-back, steering the datapath
 */
module controlFsm (
	input  logic          clk,
	input  logic          arstN,
	input  logic          run,
	input  rvPkg::opcodeT opcode,
	input  logic [2:0]    funct3,
	input  logic          funct7b5,
	input  logic          branchTaken,
	ctrlIf.fsm            ctrl,
	output logic          halted
);
	import rvPkg::*;

	stateT state;
	stateT stateNext;
	aluOpT aluFunc;
	logic writesRd;
	logic jumps;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			sIdle:      if (run) stateNext = sFetch;
			sFetch:     stateNext = sDecode;
			sDecode:    stateNext = sExecute;
			// Only LW and SW visit memory
			sExecute:   stateNext = (opcode == opLoad || opcode == opStore) ? sMemory : sWriteback;
			sMemory:    stateNext = sWriteback;
			sWriteback: stateNext = (opcode == opSystem) ? sHalt : sFetch;
			sHalt:      stateNext = sHalt;
			default:    stateNext = sIdle;
		endcase
	end

	// funct3 decode shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			// SUB only exists in the register form
			3'b000:  aluFunc = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
			3'b001:  aluFunc = aluSll;
			3'b010:  aluFunc = aluSlt;
			3'b011:  aluFunc = aluSltu;
			3'b100:  aluFunc = aluXor;
			3'b101:  aluFunc = funct7b5 ? aluSra : aluSrl;
			3'b110:  aluFunc = aluOr;
			default: aluFunc = aluAnd;
		endcase
	end

	// Operand steering, default is rs1 plus immediate
	always_comb begin
		ctrl.aluOp = aluAdd;
		ctrl.aluSrcA = 1'b0;
		ctrl.aluSrcB = 1'b1;
		ctrl.wbSel = wbAlu;
		writesRd = 1'b1;
		case (opcode)
			opLui:   ctrl.aluOp = aluPassB;
			opAuipc: ctrl.aluSrcA = 1'b1;
			opJal: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.wbSel = wbLink;
			end
			opJalr:  ctrl.wbSel = wbLink;
			opLoad:  ctrl.wbSel = wbMem;
			opStore: writesRd = 1'b0;
			opImm:   ctrl.aluOp = aluFunc;
			opReg: begin
				ctrl.aluOp = aluFunc;
				ctrl.aluSrcB = 1'b0;
			end
			opBranch: begin
				// Compare rs1/rs2 in execute, then form pc + imm as target
				ctrl.aluSrcA = (state == sWriteback);
				ctrl.aluSrcB = (state == sWriteback);
				writesRd = 1'b0;
			end
			default: begin
				ctrl.aluSrcB = 1'b0;
				writesRd = 1'b0;
			end
		endcase
	end

	assign jumps = (opcode == opJal) || (opcode == opJalr)
		|| (opcode == opBranch && branchTaken);

	// Strobes, all idle outside their state
	assign ctrl.irLoad = (state == sDecode);
	assign ctrl.memWrite = (state == sMemory) && (opcode == opStore);
	assign ctrl.retire = (state == sWriteback);
	assign ctrl.regWrite = ctrl.retire && writesRd;
	assign ctrl.pcLoad = ctrl.retire && jumps;
	assign ctrl.pcInc = ctrl.retire && !jumps;
	assign halted = (state == sHalt);

	// One retire per instruction
	assert property (@(posedge clk) disable iff (!arstN)
		ctrl.retire |=> !ctrl.retire);

	// Retire only after execute or memory
	assert property (@(posedge clk) disable iff (!arstN)
		ctrl.retire |-> ($past(state) inside {sExecute, sMemory}));

endmodule

// File: logic/coreTop.sv
/*
 * RV32I multicycle core top level
 * Datapath registers, memories, sequencer and the retire trace port
 */
module coreTop (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          run,
	input  logic                          progWe,
	input  logic [rvPkg::memAddrBits-1:0] progAddr,
	input  logic [rvPkg::xlen-1:0]        progData,
	output logic                          halted,
	output logic                          retireValid,
	output logic [rvPkg::xlen-1:0]        retirePc,
	output logic [4:0]                    retireRd,
	output logic [rvPkg::xlen-1:0]        retireData
);
	import rvPkg::*;

	ctrlIf ctrl ();

	opcodeT opcode;
	logic running;
	logic taken;
	logic takenQ;
	logic rdWritten;
	logic [memAddrBits-1:0] imemAddr;
	logic signed [xlen-1:0] imm;
	logic [xlen-1:0] ir, pc, imemRdata, dmemRdata;
	logic [xlen-1:0] rs1Data, rs2Data, aluA, aluB, aluOut;
	logic [xlen-1:0] aluResultQ, loadDataQ, wbValue;

	// Set by run, mirrors the sequencer leaving sIdle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
		end else if (run) begin
			running <= 1'b1;
		end
	end

	// Program port owns the instruction memory only while idle
	assign imemAddr = running ? pc[memAddrBits+1:2] : progAddr;

	wordMemory #(.depth(imemDepth)) imem (
		.clk(clk), .we(progWe && !running), .addr(imemAddr),
		.wdata(progData), .rdata(imemRdata)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ir <= '0;
			takenQ <= 1'b0;
		end else begin
			if (ctrl.irLoad) begin
				ir <= imemRdata;
			end
			takenQ <= taken;
		end
	end

	// Operands hold still from execute on, so these sample every cycle
	always_ff @(posedge clk) begin
		aluResultQ <= aluOut;
		loadDataQ <= dmemRdata;
	end

	assign opcode = opcodeT'(ir[6:0]);

	controlFsm fsm (
		.clk(clk), .arstN(arstN), .run(run), .opcode(opcode), .funct3(ir[14:12]),
		.funct7b5(ir[30]), .branchTaken(takenQ), .ctrl(ctrl.fsm), .halted(halted)
	);

	// Target is the live ALU sum during write-back
	programCounter pcReg (.clk(clk), .arstN(arstN), .ctrl(ctrl.dp), .target(aluOut), .pc(pc));

	immediateExtender immExt (.instruction(ir), .imm(imm));

	registerFile regFile (
		.clk(clk), .arstN(arstN), .ctrl(ctrl.dp), .rs1Addr(ir[19:15]), .rs2Addr(ir[24:20]),
		.rdAddr(ir[11:7]), .rdData(wbValue), .rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	assign aluA = ctrl.aluSrcA ? pc : rs1Data;
	assign aluB = ctrl.aluSrcB ? imm : rs2Data;

	arithmeticUnit alu (
		.opA(aluA), .opB(aluB), .aluOp(ctrl.aluOp), .funct3(ir[14:12]),
		.result(aluOut), .branchTaken(taken)
	);

	// Address read at end of execute, data lands in loadDataQ by end of memory
	wordMemory #(.depth(dmemDepth)) dmem (
		.clk(clk), .we(ctrl.memWrite), .addr(aluOut[memAddrBits+1:2]),
		.wdata(rs2Data), .rdata(dmemRdata)
	);

	always_comb begin
		case (ctrl.wbSel)
			wbMem:   wbValue = loadDataQ;
			// PC still holds this instruction's address
			wbLink:  wbValue = pc + xlen'(4);
			default: wbValue = aluResultQ;
		endcase
	end

	assign rdWritten = ctrl.regWrite && (ir[11:7] != 5'd0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			retireValid <= 1'b0;
		end else begin
			retireValid <= ctrl.retire;
		end
	end

	// Trace values hold until the next retire
	always_ff @(posedge clk) begin
		if (ctrl.retire) begin
			retirePc <= pc;
			retireRd <= ir[11:7];
			retireData <= rdWritten ? wbValue : '0;
		end
	end

endmodule

// File: tests/coreTb.sv
/*
 * Testbench for the RV32I multicycle core
 * Loads a program table, runs it and checks every retire against an expected table
 */
module coreTb;
	import rvPkg::*;

	localparam int clkPeriod = 4;
	localparam int progLen = 44;
	localparam int retireLen = 34;
	localparam int guardCycles = 8;
	localparam int settleCycles = 6;
	localparam int groupCount = 6;
	// Load, run and post-halt phases plus margin
	localparam int timeoutCycles = progLen + retireLen * 5 + guardCycles + settleCycles + 20;

	logic clk;
	logic arstN;
	logic run;
	logic progWe;
	logic [memAddrBits-1:0] progAddr;
	logic [xlen-1:0] progData;
	logic halted;
	logic retireValid;
	logic [xlen-1:0] retirePc;
	logic [4:0] retireRd;
	logic [xlen-1:0] retireData;

	// Program words by word address
	logic [31:0] progTable [progLen];
	// Expected retire stream, in retire order
	logic [31:0] expPc [retireLen];
	logic [4:0] expRd [retireLen];
	logic expRdUsed [retireLen];
	logic [31:0] expData [retireLen];
	int expGroup [retireLen];
	string groupName [groupCount];

	int wordCount = 0;
	int entryCount = 0;
	int curGroup = 0;
	int checks = 0;
	int errors = 0;
	int groupChecks = 0;
	int groupErrors = 0;
	int retireCount = 0;

	coreTop DUT (
		.clk(clk), .arstN(arstN), .run(run), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .halted(halted), .retireValid(retireValid),
		.retirePc(retirePc), .retireRd(retireRd), .retireData(retireData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Hang guard
	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Timeout: the core did not reach the end of the program in %0d cycles",
			timeoutCycles);
		$display("sim failed");
		$finish;
	end

	// Every retire pulse, expected or not
	always @(negedge clk) begin
		if (retireValid === 1'b1) begin
			retireCount++;
		end
	end

	// Instruction encoders, field order from the RV32I formats
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
		return {imm[11:0], rs1, f3, rd, opcode};
	endfunction

	function automatic logic [31:0] sType(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] upper, input logic [4:0] rd,
		input logic [6:0] opcode);
		return {upper, rd, opcode};
	endfunction

	function automatic logic [31:0] jType(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// Word that retires, with its expected trace
	task automatic emit(input logic [31:0] word, input logic rdUsed, input logic [4:0] rd,
		input logic [31:0] data);
		progTable[wordCount] = word;
		expPc[entryCount] = wordCount * 4;
		expRd[entryCount] = rd;
		expRdUsed[entryCount] = rdUsed;
		expData[entryCount] = data;
		expGroup[entryCount] = curGroup;
		wordCount++;
		entryCount++;
	endtask

	// Word that a jump or taken branch must step over
	task automatic skip();
		progTable[wordCount] = iType(32'd1, 5'd0, 3'b000, 5'd31, opImm);
		wordCount++;
	endtask

	// Taken branch over one word, then a not-taken one with the same offset
	task automatic branchPair(input logic [2:0] f3, input logic [4:0] takenRs1,
		input logic [4:0] takenRs2, input logic [4:0] notRs1, input logic [4:0] notRs2);
		emit(bType(32'd8, takenRs2, takenRs1, f3), 1'b0, 5'd0, 32'h0);
		skip();
		emit(bType(32'd8, notRs2, notRs1, f3), 1'b0, 5'd0, 32'h0);
	endtask

	// x1 = -5 and x2 = 1 feed most later checks
	task automatic buildProgram();
		groupName[0] = "immediate forms";
		groupName[1] = "upper immediates and jumps";
		groupName[2] = "branches";
		groupName[3] = "memory";
		groupName[4] = "register ALU";
		groupName[5] = "halt and load guard";
		curGroup = 0;
		emit(iType(-5, 5'd0, 3'b000, 5'd1, opImm), 1'b1, 5'd1, 32'hFFFF_FFFB);
		emit(iType(-4, 5'd1, 3'b010, 5'd2, opImm), 1'b1, 5'd2, 32'h0000_0001);
		emit(iType(32'd4, 5'd1, 3'b001, 5'd4, opImm), 1'b1, 5'd4, 32'hFFFF_FFB0);
		emit(iType(32'd28, 5'd1, 3'b101, 5'd5, opImm), 1'b1, 5'd5, 32'h0000_000F);
		// SRAI, bit 30 set in the immediate field
		emit(iType(32'h401, 5'd1, 3'b101, 5'd6, opImm), 1'b1, 5'd6, 32'hFFFF_FFFD);
		curGroup = 1;
		emit(uType(20'h80001, 5'd3, opLui), 1'b1, 5'd3, 32'h8000_1000);
		emit(uType(20'h00001, 5'd7, opAuipc), 1'b1, 5'd7, 32'h0000_1018);
		// JAL 0x1c to 0x28
		emit(jType(32'd12, 5'd8), 1'b1, 5'd8, 32'h0000_0020);
		skip();
		skip();
		emit(iType(32'h38, 5'd0, 3'b000, 5'd9, opImm), 1'b1, 5'd9, 32'h0000_0038);
		// Odd sum 0x39, lands on 0x38
		emit(iType(32'd1, 5'd9, 3'b000, 5'd10, opJalr), 1'b1, 5'd10, 32'h0000_0030);
		skip();
		skip();
		curGroup = 2;
		branchPair(3'b000, 5'd2, 5'd2, 5'd1, 5'd2);
		branchPair(3'b001, 5'd1, 5'd2, 5'd2, 5'd2);
		branchPair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1);
		branchPair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2);
		branchPair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2);
		branchPair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1);
		curGroup = 3;
		emit(iType(32'h80, 5'd0, 3'b000, 5'd11, opImm), 1'b1, 5'd11, 32'h0000_0080);
		// Both hit byte address 0x78
		emit(sType(-8, 5'd1, 5'd11), 1'b0, 5'd0, 32'h0);
		emit(iType(-8, 5'd11, 3'b010, 5'd12, opLoad), 1'b1, 5'd12, 32'hFFFF_FFFB);
		curGroup = 4;
		emit(rType(7'h20, 5'd1, 5'd2, 3'b000, 5'd13), 1'b1, 5'd13, 32'h0000_0006);
		emit(rType(7'h20, 5'd13, 5'd1, 3'b101, 5'd14), 1'b1, 5'd14, 32'hFFFF_FFFF);
		emit(rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd15), 1'b1, 5'd15, 32'h0000_0001);
		emit(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd16), 1'b1, 5'd16, 32'h0000_0000);
		// Write to x0, then read it back
		emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b1, 5'd0, 32'h0000_0000);
		emit(rType(7'h00, 5'd2, 5'd0, 3'b000, 5'd17), 1'b1, 5'd17, 32'h0000_0001);
		emit(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd18), 1'b1, 5'd18, 32'hFFFF_FFFA);
		emit(rType(7'h00, 5'd13, 5'd1, 3'b111, 5'd19), 1'b1, 5'd19, 32'h0000_0002);
		curGroup = 5;
		// ECALL
		emit(32'h0000_0073, 1'b1, 5'd0, 32'h0);
	endtask

	task automatic compareValue(input string name, input int entry, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		groupChecks++;
		if (actual !== expected) begin
			errors++;
			groupErrors++;
			$display("FAIL t=%0t entry %0d %s expected %h got %h", $time, entry, name,
				expected, actual);
		end
	endtask

	task automatic closeGroup(input int group);
		$display("%s: %0d checks, %0d errors", groupName[group], groupChecks, groupErrors);
		groupChecks = 0;
		groupErrors = 0;
	endtask

	initial begin
		int idx;
		arstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		buildProgram();
		if (wordCount != progLen || entryCount != retireLen) begin
			$display("The program or retire table does not have its declared length");
			errors++;
		end
		repeat (2) @(posedge clk);
		arstN <= 1'b1;

		// Program load while idle
		for (idx = 0; idx < progLen; idx++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= memAddrBits'(idx);
			progData <= progTable[idx];
		end
		@(posedge clk);
		progWe <= 1'b0;
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;

		// One table entry per retire pulse
		for (idx = 0; idx < retireLen; idx++) begin
			@(negedge clk);
			while (retireValid !== 1'b1) @(negedge clk);
			compareValue("retirePc", idx, expPc[idx], retirePc);
			if (expRdUsed[idx]) begin
				compareValue("retireRd", idx, {27'b0, expRd[idx]}, {27'b0, retireRd});
			end
			compareValue("retireData", idx, expData[idx], retireData);
			// High together with the halting retire only
			compareValue("halted", idx, (idx == retireLen - 1) ? 32'd1 : 32'd0,
				{31'b0, halted});
			if (idx < retireLen - 1) begin
				if (expGroup[idx + 1] != expGroup[idx]) begin
					closeGroup(expGroup[idx]);
				end
			end
		end

		// Program writes and a run pulse after halt
		for (idx = 0; idx < guardCycles; idx++) begin
			@(posedge clk);
			progWe <= (idx % 2 == 0);
			progAddr <= memAddrBits'(idx);
			progData <= jType(32'd0, 5'd1);
			run <= (idx == 3);
		end
		@(posedge clk);
		progWe <= 1'b0;
		run <= 1'b0;
		repeat (settleCycles) @(posedge clk);
		@(negedge clk);
		compareValue("halted", retireLen, 32'd1, {31'b0, halted});
		@(posedge clk);
		compareValue("retireCount", retireLen, retireLen, retireCount);
		closeGroup(5);

		$display("Total: %0d checks, %0d errors, %0d retires", checks, errors, retireCount);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: list.f
logic/rvPkg.sv
logic/ctrlIf.sv
logic/immediateExtender.sv
logic/registerFile.sv
logic/arithmeticUnit.sv
logic/programCounter.sv
logic/wordMemory.sv
logic/controlFsm.sv
logic/coreTop.sv
tests/coreTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = coreTb
FILELIST = list.f
OBJDIR = obj_dir
PASSMSG = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
